// ==== source/cipher_pkg.sv ====
// shared widths and the 4-bit substitution table; fixed 64-bit block, toy cipher and not DES
`default_nettype none

package cipher_pkg;

	// block and key width, both 64 bits
	localparam int block_w = 64;

	// each feistel half
	localparam int half_w = 32;

	// rounds in a single E or D pass
	localparam int round_cnt = 8;

	// encrypt-decrypt-encrypt, three passes per block
	localparam int pass_cnt = 3;

	// round counter width
	// must cover round_cnt - 1
	localparam int round_idx_w = 3;

	// 4-bit substitution applied to every nibble of the mixed right half
	// index is the nibble value, entry is its replacement
	localparam logic [3:0] sbox [0:15] = '{
		4'hC,
		4'h5,
		4'h6,
		4'hB,
		4'h9,
		4'h0,
		4'hA,
		4'hD,
		4'h3,
		4'hE,
		4'hF,
		4'h8,
		4'h4,
		4'h7,
		4'h1,
		4'h2
	};

endpackage

`default_nettype wire

// ==== source/ede_sequencer.sv ====
// accepts one block at a time; keys and direction are only sampled at the accepting edge
`timescale 1ns/1ps
`default_nettype none

module ede_sequencer
	import cipher_pkg::*;
(
	input  logic                 tb_clk,
	input  logic                 rst_n,
	input  logic                 rcv_data_ready,
	input  logic                 encrypt,
	input  logic [block_w-1:0]   rcv_data,
	input  logic [block_w-1:0]   key_a,
	input  logic [block_w-1:0]   key_b,
	input  logic [block_w-1:0]   key_c,
	input  logic                 holder_full,
	output logic                 load_block,
	output logic [block_w-1:0]   block_in,
	output logic [half_w-1:0]    round_key,
	output logic                 round_en,
	output logic                 last_round,
	output logic                 result_valid,
	output logic                 busy
);

	// control state
	logic                    running;
	logic                    result_q;
	logic                    enc_q;
	logic [pass_cnt-1:0]     pass_oh;
	logic [round_idx_w-1:0]  round_idx;

	// keys captured at acceptance
	logic [block_w-1:0]      key_a_q;
	logic [block_w-1:0]      key_b_q;
	logic [block_w-1:0]      key_c_q;

	// per-pass decode
	logic                    start;
	logic                    pass_dec;
	logic [block_w-1:0]      pass_key;
	logic [round_idx_w-1:0]  key_idx;
	logic [2*block_w-1:0]    key_rot;

	// a request only counts while idle and the holder is empty
	assign busy         = running | result_q | holder_full;
	assign start        = rcv_data_ready & ~busy;
	assign load_block   = start;
	assign block_in     = rcv_data;
	assign round_en     = running;
	assign last_round   = (round_idx == round_idx_w'(round_cnt - 1));
	assign result_valid = result_q;

	// EDE order
	// the middle pass always runs opposite to the outer two
	assign pass_dec = enc_q ? pass_oh[1] : ~pass_oh[1];

	always_comb
	begin
		// middle pass always uses key_b
		if (pass_oh[1])
			pass_key = key_b_q;
		// encrypt starts and decrypt ends on key_a
		else if (pass_oh[0] == enc_q)
			pass_key = key_a_q;
		else
			pass_key = key_c_q;
	end

	// decrypting passes walk the schedule backwards
	assign key_idx = pass_dec ? (round_idx_w'(round_cnt - 1) - round_idx) : round_idx;

	// rotate left by 8*i through a doubled copy
	// upper half is the result
	assign key_rot   = {pass_key, pass_key} << {key_idx, 3'b000};
	assign round_key = key_rot[2*block_w-1 -: half_w];

	// key registers, loaded by an accepted request
	always_ff @(posedge tb_clk)
	begin
		if (start)
		begin
			key_a_q <= key_a;
			key_b_q <= key_b;
			key_c_q <= key_c;
		end
	end

	always_ff @(posedge tb_clk)
	begin
		if (!rst_n)
		begin
			running   <= 1'b0;
			result_q  <= 1'b0;
			enc_q     <= 1'b0;
			pass_oh   <= '0;
			round_idx <= '0;
		end
		else
		begin
			// one-cycle strobe
			result_q <= 1'b0;
			if (start)
			begin
				running   <= 1'b1;
				enc_q     <= encrypt;
				pass_oh   <= pass_cnt'(1);
				round_idx <= '0;
			end
			else if (running)
			begin
				round_idx <= round_idx + 1'b1;
				if (last_round)
				begin
					round_idx <= '0;
					pass_oh   <= pass_oh << 1;
					// third pass done so hand off to the holder
					if (pass_oh[pass_cnt-1])
					begin
						running  <= 1'b0;
						result_q <= 1'b1;
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== source/feistel_datapath.sv ====
// one feistel round per enabled cycle, no initial or final permutation
`timescale 1ns/1ps
`default_nettype none

module feistel_datapath
	import cipher_pkg::*;
(
	input  logic                tb_clk,
	input  logic                rst_n,
	input  logic                load_block,
	input  logic [block_w-1:0]  block_in,
	input  logic                round_en,
	input  logic                last_round,
	input  logic [half_w-1:0]   round_key,
	output logic [block_w-1:0]  block_out
);

	// block halves
	logic [half_w-1:0] left_q;
	logic [half_w-1:0] right_q;

	// round function stages
	logic [half_w-1:0] key_mix;
	logic [half_w-1:0] sub_out;
	logic [half_w-1:0] f_out;

	// next values of both halves
	logic [half_w-1:0] left_nxt;
	logic [half_w-1:0] right_nxt;
	logic [half_w-1:0] mixed_left;

	// nibble substitution over a whole half
	function automatic logic [half_w-1:0] sub_half(input logic [half_w-1:0] x);
		logic [half_w-1:0] s;
		s = '0;
		for (int n = 0; n < half_w / 4; n++)
		begin
			// each nibble looked up independently
			s[4*n +: 4] = sbox[x[4*n +: 4]];
		end
		return s;
	endfunction

	// key mixing
	assign key_mix = right_q ^ round_key;

	// substitution
	assign sub_out = sub_half(key_mix);

	// diffusion
	// rotate left by 11
	assign f_out = {sub_out[half_w-12:0], sub_out[half_w-1:half_w-11]};

	// old left folded with f of old right
	assign mixed_left = left_q ^ f_out;

	always_comb
	begin
		if (last_round)
		begin
			// final round of a pass keeps the halves in place
			left_nxt  = mixed_left;
			right_nxt = right_q;
		end
		else
		begin
			// normal round swaps
			left_nxt  = right_q;
			right_nxt = mixed_left;
		end
	end

	always_ff @(posedge tb_clk)
	begin
		if (!rst_n)
		begin
			left_q  <= '0;
			right_q <= '0;
		end
		else if (load_block)
		begin
			// upper half is left
			left_q  <= block_in[block_w-1:half_w];
			right_q <= block_in[half_w-1:0];
		end
		else if (round_en)
		begin
			left_q  <= left_nxt;
			right_q <= right_nxt;
		end
	end

	// the sequencer samples this one cycle after the last round
	assign block_out = {left_q, right_q};

endmodule

`default_nettype wire

// ==== source/output_holder.sv ====
// single-entry output register; contents frozen until handshake_ack while full
`timescale 1ns/1ps
`default_nettype none

module output_holder
	import cipher_pkg::*;
(
	input  logic                tb_clk,
	input  logic                rst_n,
	input  logic                result_valid,
	input  logic [block_w-1:0]  block_out,
	input  logic                handshake_ack,
	output logic [block_w-1:0]  trans_data,
	output logic                trans_data_ready,
	output logic                holder_full
);

	// occupancy
	logic               full_q;

	// held block
	logic [block_w-1:0] data_q;

	// capture only when empty
	// sequencer keeps busy high while full, so this is a guard only
	always_ff @(posedge tb_clk)
	begin
		if (result_valid && !full_q)
			data_q <= block_out;
	end

	always_ff @(posedge tb_clk)
	begin
		if (!rst_n)
			full_q <= 1'b0;
		else if (result_valid)
			full_q <= 1'b1;
		// ack only matters while something is held
		else if (handshake_ack && full_q)
			full_q <= 1'b0;
	end

	// same flag seen by the host and by the sequencer
	assign trans_data       = data_q;
	assign trans_data_ready = full_q;
	assign holder_full      = full_q;

endmodule

`default_nettype wire

// ==== source/encryptor_core.sv ====
// top level; fixed 25-cycle latency from acceptance to trans_data_ready, one block in flight
`timescale 1ns/1ps
`default_nettype none

module encryptor_core
	import cipher_pkg::*;
(
	input  logic                tb_clk,
	input  logic                rst_n,
	input  logic                rcv_data_ready,
	input  logic                encrypt,
	input  logic [block_w-1:0]  rcv_data,
	input  logic [block_w-1:0]  key_a,
	input  logic [block_w-1:0]  key_b,
	input  logic [block_w-1:0]  key_c,
	input  logic                handshake_ack,
	output logic [block_w-1:0]  trans_data,
	output logic                trans_data_ready,
	output logic                busy
);

	// sequencer to datapath
	logic                load_block;
	logic [block_w-1:0]  block_in;
	logic [half_w-1:0]   round_key;
	logic                round_en;
	logic                last_round;

	// datapath and sequencer to holder
	logic [block_w-1:0]  block_out;
	logic                result_valid;

	// holder back to sequencer
	logic                holder_full;

	// pass and round control, key schedule
	ede_sequencer u_sequencer (
		.tb_clk         (tb_clk),
		.rst_n          (rst_n),
		.rcv_data_ready (rcv_data_ready),
		.encrypt        (encrypt),
		.rcv_data       (rcv_data),
		.key_a          (key_a),
		.key_b          (key_b),
		.key_c          (key_c),
		.holder_full    (holder_full),
		.load_block     (load_block),
		.block_in       (block_in),
		.round_key      (round_key),
		.round_en       (round_en),
		.last_round     (last_round),
		.result_valid   (result_valid),
		.busy           (busy)
	);

	// round datapath
	feistel_datapath u_datapath (
		.tb_clk     (tb_clk),
		.rst_n      (rst_n),
		.load_block (load_block),
		.block_in   (block_in),
		.round_en   (round_en),
		.last_round (last_round),
		.round_key  (round_key),
		.block_out  (block_out)
	);

	// result register toward the host
	output_holder u_holder (
		.tb_clk           (tb_clk),
		.rst_n            (rst_n),
		.result_valid     (result_valid),
		.block_out        (block_out),
		.handshake_ack    (handshake_ack),
		.trans_data       (trans_data),
		.trans_data_ready (trans_data_ready),
		.holder_full      (holder_full)
	);

endmodule

`default_nettype wire

// ==== dv/encryptor_core_chk.sv ====
// handshake and latency checks bound into encryptor_core; assumes a fixed 25-cycle latency
`timescale 1ns/1ps
`default_nettype none

module encryptor_core_chk
	import cipher_pkg::*;
(
	input logic                tb_clk,
	input logic                rst_n,
	input logic                rcv_data_ready,
	input logic                busy,
	input logic                handshake_ack,
	input logic [block_w-1:0]  trans_data,
	input logic                trans_data_ready
);

	// a pulse only counts while the core is idle
	logic accept;

	// failed assertions, read by the testbench at the end
	int   fail_cnt = 0;

	assign accept = rcv_data_ready & ~busy;

	// ready only rises 25 cycles after an accepting edge
	a_rise_after_accept : assert property (@(posedge tb_clk) disable iff (!rst_n)
		$rose(trans_data_ready) |-> $past(accept, 26))
	else
	begin
		$error("trans_data_ready rose without an acceptance 25 cycles before");
		fail_cnt++;
	end

	// and every accepted block does come out at that point
	a_accept_to_rise : assert property (@(posedge tb_clk) disable iff (!rst_n)
		$past(accept, 26) |-> $rose(trans_data_ready))
	else
	begin
		$error("accepted block did not raise trans_data_ready after 25 cycles");
		fail_cnt++;
	end

	// held output frozen until ack
	a_hold_until_ack : assert property (@(posedge tb_clk) disable iff (!rst_n)
		trans_data_ready && !handshake_ack |=> trans_data_ready && $stable(trans_data))
	else
	begin
		$error("trans_data or trans_data_ready changed before handshake_ack");
		fail_cnt++;
	end

	// ack edge clears the flag
	a_drop_on_ack : assert property (@(posedge tb_clk) disable iff (!rst_n)
		trans_data_ready && handshake_ack |=> !trans_data_ready)
	else
	begin
		$error("trans_data_ready still high after the acknowledging edge");
		fail_cnt++;
	end

	// ready cleared by every reset edge
	a_reset_clears : assert property (@(posedge tb_clk)
		!rst_n |=> !trans_data_ready)
	else
	begin
		$error("trans_data_ready high during or right after reset");
		fail_cnt++;
	end

	// busy from the accepting edge through the full holder
	// drops only at the acknowledging edge
	a_busy_until_ack : assert property (@(posedge tb_clk) disable iff (!rst_n)
		(accept || busy) && !(trans_data_ready && handshake_ack) |=> busy)
	else
	begin
		$error("busy low between acceptance and the acknowledging edge");
		fail_cnt++;
	end

endmodule

bind encryptor_core encryptor_core_chk u_chk (
	.tb_clk           (tb_clk),
	.rst_n            (rst_n),
	.rcv_data_ready   (rcv_data_ready),
	.busy             (busy),
	.handshake_ack    (handshake_ack),
	.trans_data       (trans_data),
	.trans_data_ready (trans_data_ready)
);

`default_nettype wire

// ==== dv/tb_encryptor_core.sv ====
// self-checking testbench; one block in flight, 25-cycle latency expected, run capped at 4000 cycles
`timescale 1ns/1ps
`default_nettype none

module tb_encryptor_core
	import cipher_pkg::*;
();

	localparam int timeout_cycles = 4000;

	// DUT ports
	logic                tb_clk;
	logic                rst_n;
	logic                rcv_data_ready;
	logic                encrypt;
	logic [block_w-1:0]  rcv_data;
	logic [block_w-1:0]  key_a;
	logic [block_w-1:0]  key_b;
	logic [block_w-1:0]  key_c;
	logic                handshake_ack;
	logic [block_w-1:0]  trans_data;
	logic                trans_data_ready;
	logic                busy;

	// bookkeeping
	integer              seed;
	int                  err_cnt;
	int                  check_cnt;
	int                  cycles;

	// test vectors
	logic [block_w-1:0]  pt;
	logic [block_w-1:0]  ct;
	logic [block_w-1:0]  back;
	logic [block_w-1:0]  ka;
	logic [block_w-1:0]  kb;
	logic [block_w-1:0]  kc;

	encryptor_core DUT (
		.tb_clk           (tb_clk),
		.rst_n            (rst_n),
		.rcv_data_ready   (rcv_data_ready),
		.encrypt          (encrypt),
		.rcv_data         (rcv_data),
		.key_a            (key_a),
		.key_b            (key_b),
		.key_c            (key_c),
		.handshake_ack    (handshake_ack),
		.trans_data       (trans_data),
		.trans_data_ready (trans_data_ready),
		.busy             (busy)
	);

	// 8 ns period
	always #4 tb_clk = ~tb_clk;

	// round function as key xor then nibble sbox then rotate left 11
	function automatic logic [half_w-1:0] round_func(input logic [half_w-1:0] r,
		input logic [half_w-1:0] k);
		logic [half_w-1:0] x;
		logic [half_w-1:0] s;
		x = r ^ k;
		for (int n = 0; n < half_w / 4; n++)
			s[4*n +: 4] = sbox[x[4*n +: 4]];
		return {s[20:0], s[31:21]};
	endfunction

	// upper 32 bits of the key rotated left by 8*i
	function automatic logic [half_w-1:0] round_subkey(input logic [block_w-1:0] k, input int i);
		logic [block_w-1:0] r;
		r = (k << (8 * i)) | (k >> (block_w - 8 * i));
		return r[block_w-1:half_w];
	endfunction

	// one 8-round pass with no swap after the last round
	function automatic logic [block_w-1:0] feistel_pass(input logic [block_w-1:0] blk,
		input logic [block_w-1:0] k, input bit dec);
		logic [half_w-1:0] l;
		logic [half_w-1:0] r;
		logic [half_w-1:0] t;
		int i;
		l = blk[block_w-1:half_w];
		r = blk[half_w-1:0];
		for (int step = 0; step < round_cnt; step++)
		begin
			// decrypting walks the key schedule backwards
			i = dec ? round_cnt - 1 - step : step;
			t = l ^ round_func(r, round_subkey(k, i));
			if (step == round_cnt - 1)
				l = t;
			else
			begin
				l = r;
				r = t;
			end
		end
		return {l, r};
	endfunction

	// EDE order reversed for decryption
	function automatic logic [block_w-1:0] triple_model(input logic [block_w-1:0] blk,
		input bit enc, input logic [block_w-1:0] k1, input logic [block_w-1:0] k2,
		input logic [block_w-1:0] k3);
		if (enc)
			return feistel_pass(feistel_pass(feistel_pass(blk, k1, 0), k2, 1), k3, 0);
		return feistel_pass(feistel_pass(feistel_pass(blk, k3, 1), k2, 0), k1, 1);
	endfunction

	task automatic check_value(input string name, input logic [block_w-1:0] got,
		input logic [block_w-1:0] exp);
		check_cnt++;
		assert (got === exp)
		else
		begin
			$display("mismatch %s: got %h expected %h", name, got, exp);
			err_cnt++;
		end
	endtask

	// send one block and optionally pulse again while busy
	// ack follows after a random delay
	task automatic run_block(input logic [block_w-1:0] blk, input logic enc,
		input logic [block_w-1:0] k1, input logic [block_w-1:0] k2,
		input logic [block_w-1:0] k3, input logic spam, output logic [block_w-1:0] result);
		int lat;
		int ack_delay;
		logic [block_w-1:0] held;
		ack_delay = {$random(seed)} % 11;
		while (busy)
			@(negedge tb_clk);
		rcv_data_ready = 1'b1;
		rcv_data = blk;
		encrypt = enc;
		key_a = k1;
		key_b = k2;
		key_c = k3;
		@(negedge tb_clk);
		lat = 0;
		while (!trans_data_ready)
		begin
			// inputs wander while busy and the core must ignore them
			rcv_data_ready = spam;
			rcv_data = {$random(seed), $random(seed)};
			encrypt = ~enc;
			key_a = ~k1;
			key_b = ~k2;
			key_c = ~k3;
			@(negedge tb_clk);
			lat++;
		end
		rcv_data_ready = 1'b0;
		check_value("latency", 64'(lat), 64'd25);
		check_value("busy", 64'(busy), 64'd1);
		held = trans_data;
		repeat (ack_delay)
		begin
			// full holder refuses requests too
			rcv_data_ready = spam;
			rcv_data = {$random(seed), $random(seed)};
			@(negedge tb_clk);
			check_value("trans_data_ready", 64'(trans_data_ready), 64'd1);
			check_value("trans_data held", trans_data, held);
		end
		rcv_data_ready = 1'b0;
		handshake_ack = 1'b1;
		@(negedge tb_clk);
		handshake_ack = 1'b0;
		// fell at the ack edge and the core is free again
		check_value("trans_data_ready after ack", 64'(trans_data_ready), 64'd0);
		check_value("busy after ack", 64'(busy), 64'd0);
		result = held;
	endtask

	always @(posedge tb_clk)
	begin
		cycles = cycles + 1;
		if (cycles >= timeout_cycles)
		begin
			$display("error: run stopped after %0d cycles without finishing the tests", cycles);
			$display("checks: %0d, errors: %0d, assertion failures: %0d", check_cnt,
				err_cnt + 1, DUT.u_chk.fail_cnt);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	initial
	begin
		tb_clk = 1'b0;
		rst_n = 1'b0;
		rcv_data_ready = 1'b0;
		encrypt = 1'b0;
		rcv_data = '0;
		key_a = '0;
		key_b = '0;
		key_c = '0;
		handshake_ack = 1'b0;
		seed = 32'h9bfa_b1d7;
		err_cnt = 0;
		check_cnt = 0;
		cycles = 0;
		repeat (10) @(negedge tb_clk);
		rst_n = 1'b1;
		@(negedge tb_clk);
		// idle after reset
		check_value("trans_data_ready", 64'(trans_data_ready), 64'd0);
		check_value("busy", 64'(busy), 64'd0);
		// random EDE blocks, each fed back with encrypt low
		for (int b = 0; b < 16; b++)
		begin
			pt = {$random(seed), $random(seed)};
			ka = {$random(seed), $random(seed)};
			kb = {$random(seed), $random(seed)};
			kc = {$random(seed), $random(seed)};
			run_block(pt, 1'b1, ka, kb, kc, b % 2 == 1, ct);
			check_value("trans_data", ct, triple_model(pt, 1'b1, ka, kb, kc));
			run_block(ct, 1'b0, ka, kb, kc, b % 3 == 0, back);
			check_value("trans_data round trip", back, pt);
		end
		// equal keys collapse to one pass
		for (int b = 0; b < 8; b++)
		begin
			pt = {$random(seed), $random(seed)};
			ka = {$random(seed), $random(seed)};
			run_block(pt, 1'b1, ka, ka, ka, b % 2 == 0, ct);
			check_value("trans_data equal keys", ct, feistel_pass(pt, ka, 1'b0));
		end
		$display("checks: %0d, errors: %0d, assertion failures: %0d", check_cnt, err_cnt,
			DUT.u_chk.fail_cnt);
		if (err_cnt == 0 && DUT.u_chk.fail_cnt == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== flist.f ====
source/cipher_pkg.sv
source/ede_sequencer.sv
source/feistel_datapath.sv
source/output_holder.sv
source/encryptor_core.sv
dv/encryptor_core_chk.sv
dv/tb_encryptor_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the encryptor_core testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --assert --top-module tb_encryptor_core -f flist.f -o tb_sim \
	|| { echo "Verilator build failed"; exit 1; }

# a raised error limit lets the run reach its own closing lines
./obj_dir/tb_sim +verilator+error+limit+100 > sim.log 2>&1 \
	|| echo "simulator returned an error status"
cat sim.log

grep -q "Simulation finished: FAIL" sim.log && { echo "RESULT: FAIL"; exit 1; }
grep -q "Simulation finished: PASS" sim.log || { echo "RESULT: FAIL, no pass line"; exit 1; }
echo "RESULT: PASS"
